// ==== include/lsu_config.svh ====
/*
 * Widths, buffer and pipe depths, and exception cause codes
 * for the load/store unit
 */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width
`define LSU_XLEN 32

// Transaction tag width
`define LSU_TRANS_ID_BITS 3

// Result return path depths
`define LSU_LOAD_PIPE_REGS 1
`define LSU_STORE_PIPE_REGS 1

// Request buffer entries
`define LSU_BUF_DEPTH 2

// RISC-V exception causes
`define LSU_CAUSE_LD_MISALIGNED 4'd4
`define LSU_CAUSE_ST_MISALIGNED 4'd6

`endif

// ==== lsu_top.f ====
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_bypass.sv
rtl/lsu_load_align.sv
rtl/lsu_ctrl.sv
rtl/lsu_result_pipe.sv
rtl/lsu_top.sv
sim/lsu_mem_model.sv
sim/tb_lsu_top.sv

// ==== rtl/lsu_agu.sv ====
/*
 * Address generation: effective address, byte enables,
 * store data lane alignment and misalignment exception
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_agu (
  input  logic [`LSU_XLEN-1:0]          operand_a_i,
  input  logic [`LSU_XLEN-1:0]          imm_i,
  input  logic [`LSU_XLEN-1:0]          operand_b_i,
  input  lsu_pkg::lsu_op_e              op_i,
  input  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i,
  output lsu_pkg::lsu_req_t             req_o
);

  logic [`LSU_XLEN-1:0]   vaddr;
  logic [1:0]             offset;
  logic                   is_half;
  logic                   is_word;
  logic                   is_store;
  logic                   misaligned;
  logic [`LSU_XLEN/8-1:0] be;

  // Two's complement add covers the signed immediate
  assign vaddr  = operand_a_i + imm_i;
  assign offset = vaddr[1:0];

  // ----------------------------------------------------------------------
  // Access size and direction
  // ----------------------------------------------------------------------
  always_comb begin
    is_half  = 1'b0;
    is_word  = 1'b0;
    is_store = 1'b0;
    case (op_i)
      lsu_pkg::LH, lsu_pkg::LHU: begin
        is_half = 1'b1;
      end
      lsu_pkg::LW: begin
        is_word = 1'b1;
      end
      lsu_pkg::SB: begin
        is_store = 1'b1;
      end
      lsu_pkg::SH: begin
        is_store = 1'b1;
        is_half  = 1'b1;
      end
      lsu_pkg::SW: begin
        is_store = 1'b1;
        is_word  = 1'b1;
      end
      default: ;
    endcase
  end

  // Byte enables follow size and low address bits
  always_comb begin
    if (is_word) begin
      be = 4'b1111;
    end else if (is_half) begin
      be = 4'b0011 << offset;
    end else begin
      be = 4'b0001 << offset;
    end
  end

  // Half on odd address, word off a word boundary
  assign misaligned = (is_half && offset[0]) || (is_word && (offset != 2'b00));

  // ----------------------------------------------------------------------
  // Request assembly
  // ----------------------------------------------------------------------
  always_comb begin
    req_o          = '0;
    req_o.trans_id = trans_id_i;
    req_o.op       = op_i;
    req_o.is_store = is_store;
    req_o.vaddr    = vaddr;
    req_o.be       = be;
    req_o.wdata    = operand_b_i << {offset, 3'b000};
    if (misaligned) begin
      req_o.ex.valid = 1'b1;
      req_o.ex.cause = is_store ? `LSU_CAUSE_ST_MISALIGNED : `LSU_CAUSE_LD_MISALIGNED;
      req_o.ex.tval  = vaddr;
    end
  end

endmodule

// ==== rtl/lsu_bypass.sv ====
/*
 * Two-entry circular request buffer between issue and the
 * control FSM; produces the issue-side ready
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_bypass (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              pop_i,
  output lsu_pkg::lsu_req_t head_o,
  output logic              head_valid_o,
  output logic              ready_o
);

  localparam int unsigned PTR_W = (`LSU_BUF_DEPTH > 1) ? $clog2(`LSU_BUF_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(`LSU_BUF_DEPTH + 1);

  lsu_pkg::lsu_req_t buf_q [`LSU_BUF_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(`LSU_BUF_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      buf_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  assign head_o       = buf_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  // Full buffer still accepts when the head leaves this cycle
  assign ready_o      = (count_q != CNT_W'(`LSU_BUF_DEPTH)) || pop_i;

endmodule

// ==== rtl/lsu_ctrl.sv ====
/*
 * Control FSM: runs the head request on the four-phase memory
 * port or reports its exception, and forms load and store results
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lsu_pkg::lsu_req_t     head_i,
  input  logic                  head_valid_i,
  output logic                  pop_o,
  output logic                  mem_req_o,
  output lsu_pkg::mem_req_t     mem_o,
  input  logic                  mem_ack_i,
  input  logic [`LSU_XLEN-1:0]  mem_rdata_i,
  output lsu_pkg::lsu_result_t  load_o,
  output lsu_pkg::lsu_result_t  store_o
);

  typedef enum logic [1:0] {IDLE, REQ, DRAIN} state_e;

  state_e               state_q;
  logic                 pop_q;
  logic                 start;
  logic [`LSU_XLEN-1:0] ld_data;
  lsu_pkg::lsu_result_t ex_res;
  lsu_pkg::lsu_result_t ld_res;
  lsu_pkg::lsu_result_t st_res;
  lsu_pkg::lsu_result_t load_q;
  lsu_pkg::lsu_result_t store_q;

  lsu_load_align lsu_load_align_i (
    .rdata_i  (mem_rdata_i),
    .op_i     (head_i.op),
    .offset_i (head_i.vaddr[1:0]),
    .data_o   (ld_data)
  );

  // The head seen while a pop is in flight is the one just finished
  assign start = (state_q == IDLE) && head_valid_i && !pop_q;

  // ----------------------------------------------------------------------
  // Result candidates
  // ----------------------------------------------------------------------
  always_comb begin
    ex_res          = '0;
    ex_res.valid    = 1'b1;
    ex_res.trans_id = head_i.trans_id;
    ex_res.ex       = head_i.ex;

    ld_res          = '0;
    ld_res.valid    = 1'b1;
    ld_res.trans_id = head_i.trans_id;
    ld_res.result   = ld_data;

    st_res          = '0;
    st_res.valid    = 1'b1;
    st_res.trans_id = head_i.trans_id;
  end

  // ----------------------------------------------------------------------
  // FSM and registered results
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      pop_q   <= 1'b0;
      load_q  <= '0;
      store_q <= '0;
    end else begin
      pop_q         <= 1'b0;
      load_q.valid  <= 1'b0;
      store_q.valid <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            if (head_i.ex.valid) begin
              // Misaligned, report without touching memory
              pop_q <= 1'b1;
              if (head_i.is_store) begin
                store_q <= ex_res;
              end else begin
                load_q <= ex_res;
              end
            end else if (!mem_ack_i) begin
              state_q <= REQ;
            end
          end
        end
        REQ: begin
          if (mem_ack_i) begin
            pop_q   <= 1'b1;
            state_q <= DRAIN;
            if (head_i.is_store) begin
              store_q <= st_res;
            end else begin
              load_q <= ld_res;
            end
          end
        end
        DRAIN: begin
          // Wait for the memory to close the handshake
          if (!mem_ack_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload held stable by the buffer until the pop
  assign mem_req_o   = (state_q == REQ);
  assign mem_o.addr  = {head_i.vaddr[`LSU_XLEN-1:2], 2'b00};
  assign mem_o.we    = head_i.is_store;
  assign mem_o.be    = head_i.be;
  assign mem_o.wdata = head_i.wdata;

  assign pop_o   = pop_q;
  assign load_o  = load_q;
  assign store_o = store_q;

endmodule

// ==== rtl/lsu_load_align.sv ====
/*
 * Load data extraction with sign or zero extension
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_load_align (
  input  logic [`LSU_XLEN-1:0] rdata_i,
  input  lsu_pkg::lsu_op_e     op_i,
  input  logic [1:0]           offset_i,
  output logic [`LSU_XLEN-1:0] data_o
);

  logic [`LSU_XLEN-1:0] shifted;

  // Move the addressed lane down to bit 0
  assign shifted = rdata_i >> {offset_i, 3'b000};

  always_comb begin
    case (op_i)
      lsu_pkg::LB:  data_o = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      lsu_pkg::LBU: data_o = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
      lsu_pkg::LH:  data_o = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      lsu_pkg::LHU: data_o = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
      // Full word, offset is zero for a legal access
      default:      data_o = rdata_i;
    endcase
  end

endmodule

// ==== rtl/lsu_pkg.sv ====
/*
 * Load/store unit types: operation encoding, exception record,
 * buffered request, memory port payload and result record
 */
`include "lsu_config.svh"

package lsu_pkg;

  // Supported 32-bit integer load and store operations
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LBU = 4'd1,
    LH  = 4'd2,
    LHU = 4'd3,
    LW  = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_op_e;

  typedef struct packed {
    logic                 valid;
    logic [3:0]           cause;
    logic [`LSU_XLEN-1:0] tval;
  } lsu_ex_t;

  // One entry of the request buffer
  typedef struct packed {
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    lsu_op_e                       op;
    logic                          is_store;
    logic [`LSU_XLEN-1:0]          vaddr;
    logic [`LSU_XLEN/8-1:0]        be;
    logic [`LSU_XLEN-1:0]          wdata;
    lsu_ex_t                       ex;
  } lsu_req_t;

  // Memory port payload, addr is word aligned
  typedef struct packed {
    logic [`LSU_XLEN-1:0]   addr;
    logic                   we;
    logic [`LSU_XLEN/8-1:0] be;
    logic [`LSU_XLEN-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic                          valid;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    logic [`LSU_XLEN-1:0]          result;
    lsu_ex_t                       ex;
  } lsu_result_t;

endpackage

// ==== rtl/lsu_result_pipe.sv ====
/*
 * Reset-cleared shift register over any payload type
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_result_pipe #(
  parameter type         payload_t = logic [`LSU_XLEN-1:0],
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t d_i,
  output payload_t d_o
);

  if (DEPTH == 0) begin : gen_pass
    assign d_o = d_i;
  end else begin : gen_regs
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        stage_q <= '{default: '0};
      end else begin
        stage_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[DEPTH-1];
  end

endmodule

// ==== rtl/lsu_top.sv ====
/*
 * Load/store unit top level: AGU, request buffer, control FSM
 * and the load and store result pipes
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          lsu_valid_i,
  input  logic [`LSU_XLEN-1:0]          operand_a_i,
  input  logic [`LSU_XLEN-1:0]          imm_i,
  input  logic [`LSU_XLEN-1:0]          operand_b_i,
  input  lsu_pkg::lsu_op_e              op_i,
  input  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i,
  output logic                          lsu_ready_o,
  output logic                          mem_req_o,
  output lsu_pkg::mem_req_t             mem_o,
  input  logic                          mem_ack_i,
  input  logic [`LSU_XLEN-1:0]          mem_rdata_i,
  output lsu_pkg::lsu_result_t          load_o,
  output lsu_pkg::lsu_result_t          store_o
);

  lsu_pkg::lsu_req_t    issue_req;
  lsu_pkg::lsu_req_t    head;
  logic                 head_valid;
  logic                 pop;
  logic                 push;
  lsu_pkg::lsu_result_t load_res;
  lsu_pkg::lsu_result_t store_res;

  // Issue handshake
  assign push = lsu_valid_i && lsu_ready_o;

  lsu_agu lsu_agu_i (
    .operand_a_i (operand_a_i),
    .imm_i       (imm_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .trans_id_i  (trans_id_i),
    .req_o       (issue_req)
  );

  lsu_bypass lsu_bypass_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .req_i        (issue_req),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .ready_o      (lsu_ready_o)
  );

  lsu_ctrl lsu_ctrl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .head_valid_i (head_valid),
    .pop_o        (pop),
    .mem_req_o    (mem_req_o),
    .mem_o        (mem_o),
    .mem_ack_i    (mem_ack_i),
    .mem_rdata_i  (mem_rdata_i),
    .load_o       (load_res),
    .store_o      (store_res)
  );

  // ----------------------------------------------------------------------
  // Result return paths
  // ----------------------------------------------------------------------
  lsu_result_pipe #(
    .payload_t (lsu_pkg::lsu_result_t),
    .DEPTH     (`LSU_LOAD_PIPE_REGS)
  ) load_pipe_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (load_res),
    .d_o    (load_o)
  );

  lsu_result_pipe #(
    .payload_t (lsu_pkg::lsu_result_t),
    .DEPTH     (`LSU_STORE_PIPE_REGS)
  ) store_pipe_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (store_res),
    .d_o    (store_o)
  );

endmodule

// ==== sim/lsu_mem_model.sv ====
/*
 * Word-addressed memory of 256 words, slave side of the four-phase
 * req/ack port with random delays before each ack edge
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_mem_model #(
  parameter int SEED = 32'h64c082cc
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mem_req_i,
  input  lsu_pkg::mem_req_t    mem_i,
  output logic                 mem_ack_o,
  output logic [`LSU_XLEN-1:0] mem_rdata_o
);

  typedef enum logic [1:0] {WAIT_REQ, DELAY_UP, HOLD_ACK, DELAY_DOWN} state_e;

  logic [`LSU_XLEN-1:0] mem_q [256];
  state_e               state_q;
  logic [1:0]           cnt_q;
  int                   seed = SEED;

  // Extra wait of 0 to 3 cycles
  function automatic logic [1:0] next_delay();
    logic [31:0] r;
    r = $random(seed);
    return r[1:0];
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem_q[i] = '0;
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= WAIT_REQ;
      cnt_q       <= '0;
      mem_ack_o   <= 1'b0;
      mem_rdata_o <= '0;
    end else begin
      case (state_q)
        WAIT_REQ: begin
          if (mem_req_i) begin
            cnt_q   <= next_delay();
            state_q <= DELAY_UP;
          end
        end
        DELAY_UP: begin
          if (cnt_q == 2'd0) begin
            mem_ack_o <= 1'b1;
            state_q   <= HOLD_ACK;
            if (mem_i.we) begin
              for (int i = 0; i < 4; i++) begin
                if (mem_i.be[i]) begin
                  mem_q[mem_i.addr[9:2]][8*i +: 8] <= mem_i.wdata[8*i +: 8];
                end
              end
            end else begin
              // Read data stays valid for as long as ack is high
              mem_rdata_o <= mem_q[mem_i.addr[9:2]];
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        HOLD_ACK: begin
          if (!mem_req_i) begin
            cnt_q   <= next_delay();
            state_q <= DELAY_DOWN;
          end
        end
        default: begin
          if (cnt_q == 2'd0) begin
            mem_ack_o <= 1'b0;
            state_q   <= WAIT_REQ;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
      endcase
    end
  end

endmodule

// ==== sim/tb_lsu_top.sv ====
/*
 * Testbench for the load/store unit: clock, reset, directed and random
 * issue, byte-level reference model, assertions and watchdog
 */
`timescale 1ns/1ns
`include "lsu_config.svh"

module tb_lsu_top;

  localparam int CLK_PERIOD_NS = 20;
  localparam int RESET_CYCLES  = 10;
  localparam int NUM_DIRECTED  = 21;
  localparam int NUM_RANDOM    = 150;
  localparam int NUM_BURST     = 40;
  localparam int NUM_INSTR     = NUM_DIRECTED + NUM_RANDOM + NUM_BURST;
  localparam int WATCHDOG_NS   = (RESET_CYCLES + 200 * NUM_INSTR) * CLK_PERIOD_NS;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic                          lsu_valid_i;
  logic [`LSU_XLEN-1:0]          operand_a_i;
  logic [`LSU_XLEN-1:0]          imm_i;
  logic [`LSU_XLEN-1:0]          operand_b_i;
  lsu_pkg::lsu_op_e              op_i;
  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i;
  logic                          lsu_ready_o;
  logic                          mem_req_o;
  lsu_pkg::mem_req_t             mem_o;
  logic                          mem_ack_i;
  logic [`LSU_XLEN-1:0]          mem_rdata_i;
  lsu_pkg::lsu_result_t          load_o;
  lsu_pkg::lsu_result_t          store_o;

  // Reference state, updated in issue order
  logic [7:0]                    ref_mem [1024];
  lsu_pkg::lsu_result_t          exp_res_q [$];
  logic                          exp_store_q [$];
  lsu_pkg::mem_req_t             exp_mem_q [$];
  logic [`LSU_TRANS_ID_BITS-1:0] next_tid;
  int                            seed;
  logic                          saw_stall;

  lsu_pkg::mem_req_t             mem_exp;
  lsu_pkg::mem_req_t             mem_act;
  lsu_pkg::mem_req_t             mem_o_last;
  logic                          req_seen;
  lsu_pkg::lsu_result_t          res_exp;
  lsu_pkg::lsu_result_t          res_act;
  logic                          res_store;

  lsu_top lsu_top_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_valid_i (lsu_valid_i),
    .operand_a_i (operand_a_i),
    .imm_i       (imm_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .trans_id_i  (trans_id_i),
    .lsu_ready_o (lsu_ready_o),
    .mem_req_o   (mem_req_o),
    .mem_o       (mem_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .load_o      (load_o),
    .store_o     (store_o)
  );

  lsu_mem_model mem_model_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mem_req_i   (mem_req_o),
    .mem_i       (mem_o),
    .mem_ack_o   (mem_ack_i),
    .mem_rdata_o (mem_rdata_i)
  );

  initial begin
    forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // Failure reporting
  // ------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
    $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("[FAIL] %s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  function automatic int unsigned access_size(input lsu_pkg::lsu_op_e op);
    case (op)
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
      lsu_pkg::LW, lsu_pkg::SW:               return 4;
      default:                                return 1;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

  task automatic model_access(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                              input logic [31:0] data, input logic [2:0] tid);
    int unsigned          size;
    logic                 store;
    logic [31:0]          val;
    lsu_pkg::lsu_result_t res;
    lsu_pkg::mem_req_t    mreq;
    size  = access_size(op);
    store = (op == lsu_pkg::SB) || (op == lsu_pkg::SH) || (op == lsu_pkg::SW);
    res          = '0;
    res.valid    = 1'b1;
    res.trans_id = tid;
    if ((addr % size) != 0) begin
      res.ex.valid = 1'b1;
      res.ex.cause = store ? 4'd6 : 4'd4;
      res.ex.tval  = addr;
    end else begin
      mreq      = '0;
      mreq.addr = {addr[31:2], 2'b00};
      mreq.we   = store;
      val       = '0;
      for (int i = 0; i < size; i++) begin
        mreq.be[addr[1:0] + i]              = 1'b1;
        mreq.wdata[8*(addr[1:0] + i) +: 8] = data[8*i +: 8];
        if (store) begin
          ref_mem[addr[9:0] + i] = data[8*i +: 8];
        end else begin
          val[8*i +: 8] = ref_mem[addr[9:0] + i];
        end
      end
      if (op == lsu_pkg::LB && val[7]) val[31:8] = '1;
      if (op == lsu_pkg::LH && val[15]) val[31:16] = '1;
      res.result = store ? 32'd0 : val;
      exp_mem_q.push_back(mreq);
    end
    exp_res_q.push_back(res);
    exp_store_q.push_back(store);
  endtask

  // ------------------------------------------------------------------
  // Issue side, driven on the falling edge
  // ------------------------------------------------------------------
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk_i);
      lsu_valid_i = 1'b0;
    end
  endtask

  task automatic issue_op(input lsu_pkg::lsu_op_e op, input logic [31:0] base,
                          input logic [31:0] imm, input logic [31:0] data);
    @(negedge clk_i);
    lsu_valid_i = 1'b1;
    op_i        = op;
    operand_a_i = base;
    imm_i       = imm;
    operand_b_i = data;
    trans_id_i  = next_tid;
    // Ready only changes on the rising edge
    while (!lsu_ready_o) begin
      saw_stall = 1'b1;
      @(negedge clk_i);
    end
    model_access(op, base + imm, data, next_tid);
    next_tid = next_tid + 1'b1;
  endtask

  // Negative offset from a base above the target
  task automatic directed_op(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
    issue_op(op, addr + 32'd20, 32'hFFFF_FFEC, data);
  endtask

  task automatic random_op(input logic with_gaps);
    lsu_pkg::lsu_op_e op;
    logic [31:0]      r;
    logic [31:0]      addr;
    logic [31:0]      imm;
    r    = $random(seed);
    op   = lsu_pkg::lsu_op_e'({1'b0, r[2:0]});
    r    = $random(seed);
    addr = r & 32'h0000_00FF;
    r    = $random(seed);
    // Three in four accesses are aligned
    if (r[1:0] != 2'd0) addr = addr & ~32'(access_size(op) - 1);
    imm = $random(seed) % 64;
    if (with_gaps) begin
      r = $random(seed);
      idle_cycles(r[1:0]);
    end
    issue_op(op, addr - imm, imm, $random(seed));
  endtask

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> mem_req_o)
    else report_mismatch("mem_req_hold", 1, 0);

  req_after_ack_low_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req_o) |-> !mem_ack_i)
    else report_mismatch("mem_ack_at_new_req", 0, 1);

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      req_seen = 1'b0;
    end else begin
      if (mem_req_o && !req_seen) begin
        if (exp_mem_q.size() == 0) begin
          abort_run("memory request raised with no aligned access outstanding");
        end else begin
          mem_exp       = exp_mem_q.pop_front();
          mem_act       = mem_o;
          mem_act.wdata = mem_o.wdata & lane_mask(mem_o.be);
          assert (mem_act == mem_exp) else report_mismatch("mem_request", mem_exp, mem_act);
        end
      end else if (mem_req_o) begin
        assert (mem_o == mem_o_last) else report_mismatch("mem_o_stable", mem_o_last, mem_o);
      end
      req_seen   = mem_req_o;
      mem_o_last = mem_o;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && (load_o.valid || store_o.valid)) begin
      if (load_o.valid && store_o.valid) begin
        abort_run("load and store results returned in the same cycle");
      end else if (exp_res_q.size() == 0) begin
        abort_run("result returned with no instruction outstanding");
      end else begin
        res_exp   = exp_res_q.pop_front();
        res_store = exp_store_q.pop_front();
        res_act   = store_o.valid ? store_o : load_o;
        assert (store_o.valid == res_store)
          else report_mismatch("result_port", res_store, store_o.valid);
        assert (res_act == res_exp) else report_mismatch("result", res_exp, res_act);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before all results returned");
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    seed        = 32'h64c082cc;
    rst_ni      = 1'b0;
    lsu_valid_i = 1'b0;
    operand_a_i = '0;
    imm_i       = '0;
    operand_b_i = '0;
    op_i        = lsu_pkg::LB;
    trans_id_i  = '0;
    next_tid    = '0;
    saw_stall   = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    assert (lsu_ready_o) else report_mismatch("reset_ready", 1, lsu_ready_o);
    assert ({mem_req_o, load_o.valid, store_o.valid} == 3'b000)
      else report_mismatch("reset_idle", 0, {mem_req_o, load_o.valid, store_o.valid});
    rst_ni = 1'b1;

    // Store then reload every lane of one word
    directed_op(lsu_pkg::SW, 32'h40, 32'h7F91_A25C);
    directed_op(lsu_pkg::LW, 32'h40, 32'h0);
    for (int off = 0; off < 4; off++) begin
      directed_op(lsu_pkg::LB, 32'h40 + off, 32'h0);
      directed_op(lsu_pkg::LBU, 32'h40 + off, 32'h0);
    end
    for (int off = 0; off < 4; off += 2) begin
      directed_op(lsu_pkg::LH, 32'h40 + off, 32'h0);
      directed_op(lsu_pkg::LHU, 32'h40 + off, 32'h0);
    end
    directed_op(lsu_pkg::SB, 32'h41, 32'h0000_005A);
    directed_op(lsu_pkg::SH, 32'h42, 32'h0000_C3D4);
    directed_op(lsu_pkg::LW, 32'h40, 32'h0);

    // Misaligned half and word accesses
    directed_op(lsu_pkg::LH, 32'h41, 32'h0);
    directed_op(lsu_pkg::LW, 32'h42, 32'h0);
    directed_op(lsu_pkg::SH, 32'h43, 32'h1234);
    directed_op(lsu_pkg::SW, 32'h45, 32'h5678);

    repeat (NUM_RANDOM) random_op(1'b1);
    // Back-to-back issue to fill the buffer
    repeat (NUM_BURST) random_op(1'b0);
    idle_cycles(1);

    while (exp_res_q.size() != 0) @(negedge clk_i);
    idle_cycles(8);
    assert (saw_stall) else abort_run("issue back-pressure was never observed");
    assert (exp_mem_q.size() == 0)
      else report_mismatch("mem_requests_left", 0, exp_mem_q.size());
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
